//--- flist.f
+incdir+include
design/sram_bank_pkg.sv
design/ahb_access_ctrl.sv
design/byte_lane_steer.sv
design/sram_byte_array.sv
design/sram_bank_top.sv
tb/sram_bank_tb.sv

//--- Makefile
SIM   := verilator
FLAGS := --binary --timing --assert --timescale 1ns/1ns
TOP   := sram_bank_tb
FLIST := flist.f

.PHONY: simulate clean

# pass only when the pass message shows up in the simulation output
simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Test passed"

clean:
	rm -rf obj_dir

//--- tb/sram_bank_tb.sv
/*
  Testbench for the AHB SRAM bank.
  Runs AHB transfers against a byte model of the RAM and checks each response.
*/
`timescale 1ns/1ns
`default_nettype none
`include "sram_bank_settings.svh"

module sram_bank_tb;

  localparam int MAX_CYCLES = 2000;   // test itself runs about 150 cycles

  logic                             mem_hclk;
  logic                             mem_hrst_b;
  logic                             i_hsel;
  logic [`SRAM_BANK_ADDR_WIDTH-1:0] i_haddr;
  sram_bank_pkg::htrans_e           i_htrans;
  sram_bank_pkg::hsize_e            i_hsize;
  logic                             i_hwrite;
  logic [`SRAM_BANK_DATA_WIDTH-1:0] i_hwdata;
  logic                             i_big_endian_b;
  logic                             i_rd_deny;
  logic                             i_wr_deny;
  logic [`SRAM_BANK_DATA_WIDTH-1:0] o_hrdata;
  logic                             o_hready;
  sram_bank_pkg::hresp_e            o_hresp;
  logic                             o_idle;
  logic [7:0]                       ref_mem [0:(1 << `SRAM_BANK_ADDR_WIDTH)-1];
  integer                           seed = 52;
  int                               cycle_count = 0;

  sram_bank_top UUT (.*);

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] act);
    abort_run($sformatf("ERROR at %0t ns: %s expected 0x%h, got 0x%h", $time, name, exp, act));
  endtask

  initial
  begin
    mem_hclk = 1'b0;
    forever #2 mem_hclk = ~mem_hclk;
  end

  always @(posedge mem_hclk)
  begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES)
      abort_run($sformatf("timeout: run still going after %0d cycles", MAX_CYCLES));
  end

  // a stall (held read or first error cycle) lasts one cycle only
  assert property (@(posedge mem_hclk) disable iff (!mem_hrst_b) !o_hready |=> o_hready)
    else abort_run("o_hready stayed low for more than one cycle");

  // bytes flip within the unit in big-endian mode
  function automatic int lane_flip(input sram_bank_pkg::hsize_e size);
    case (size)
      sram_bank_pkg::BYTE:     return 3;
      sram_bank_pkg::HALFWORD: return 2;
      default:                 return 0;
    endcase
  endfunction

  function automatic bit lane_enabled(input logic [15:0] addr, input sram_bank_pkg::hsize_e size,
                                      input int b);
    case (size)
      sram_bank_pkg::BYTE:     return b == int'(addr[1:0]);
      sram_bank_pkg::HALFWORD: return (b / 2) == int'(addr[1]);
      default:                 return 1'b1;
    endcase
  endfunction

  task automatic model_write(input logic [15:0] addr, input sram_bank_pkg::hsize_e size,
                             input logic [31:0] data);
    int src;
    for (int b = 0; b < 4; b++)
    begin
      src = i_big_endian_b ? b : (b ^ lane_flip(size));
      if (lane_enabled(addr, size, b))
        ref_mem[{addr[15:2], 2'(b)}] = data[src*8 +: 8];
    end
  endtask

  function automatic logic [31:0] expected_rdata(input logic [15:0] addr,
                                                 input sram_bank_pkg::hsize_e size);
    logic [31:0] res;
    res = '0;
    for (int b = 0; b < 4; b++)
    begin
      if (i_big_endian_b)
        res[b*8 +: 8] = ref_mem[{addr[15:2], 2'(b)}];   // whole word
      else if (lane_enabled(addr, size, b))
        res[(b ^ lane_flip(size))*8 +: 8] = ref_mem[{addr[15:2], 2'(b)}];
    end
    return res;
  endfunction

  task automatic step_cycle();
    @(posedge mem_hclk);
    #1;
  endtask

  task automatic address_phase(input logic [15:0] addr, input sram_bank_pkg::hsize_e size,
                               input logic write, input logic deny);
    i_hsel    = 1'b1;
    i_htrans  = sram_bank_pkg::NONSEQ;
    i_haddr   = addr;
    i_hsize   = size;
    i_hwrite  = write;
    i_wr_deny = write && deny;
    i_rd_deny = !write && deny;
  endtask

  task automatic bus_idle();
    i_hsel    = 1'b0;
    i_htrans  = sram_bank_pkg::IDLE;
    i_hwrite  = 1'b0;
    i_wr_deny = 1'b0;
    i_rd_deny = 1'b0;
  endtask

  // returns at the falling edge of the cycle that ends the data phase
  task automatic wait_data_phase(input int exp_stalls);
    int stalls;
    stalls = 0;
    @(negedge mem_hclk);
    while (!o_hready)
    begin
      stalls++;
      @(negedge mem_hclk);
    end
    assert (stalls == exp_stalls)
      else abort_run($sformatf("data phase took %0d wait cycles, expected %0d",
                               stalls, exp_stalls));
    assert (o_hresp == sram_bank_pkg::OKAY)
      else value_error("o_hresp", 32'(sram_bank_pkg::OKAY), 32'(o_hresp));
  endtask

  task automatic single_write(input logic [15:0] addr, input sram_bank_pkg::hsize_e size,
                              input logic [31:0] data);
    step_cycle();
    address_phase(addr, size, 1'b1, 1'b0);
    step_cycle();
    bus_idle();
    i_hwdata = data;
    wait_data_phase(0);
    assert (!o_idle) else value_error("o_idle", 32'd0, 32'(o_idle));   // write pending
    model_write(addr, size, data);
  endtask

  task automatic finish_read(input logic [15:0] addr, input sram_bank_pkg::hsize_e size,
                             input int exp_stalls);
    step_cycle();
    bus_idle();
    wait_data_phase(exp_stalls);
    assert (o_hrdata == expected_rdata(addr, size))
      else value_error("o_hrdata", expected_rdata(addr, size), o_hrdata);
  endtask

  task automatic single_read(input logic [15:0] addr, input sram_bank_pkg::hsize_e size);
    step_cycle();
    address_phase(addr, size, 1'b0, 1'b0);
    finish_read(addr, size, 0);
  endtask

  // read address phase sits in the write's data phase
  task automatic write_then_read(input logic [15:0] addr, input logic [31:0] data);
    step_cycle();
    address_phase(addr, sram_bank_pkg::WORD, 1'b1, 1'b0);
    step_cycle();
    address_phase(addr, sram_bank_pkg::WORD, 1'b0, 1'b0);
    i_hwdata = data;
    @(negedge mem_hclk);
    assert (o_hready) else value_error("o_hready", 32'd1, 32'(o_hready));
    model_write(addr, sram_bank_pkg::WORD, data);
    finish_read(addr, sram_bank_pkg::WORD, 1);
  endtask

  task automatic denied_access(input logic [15:0] addr, input logic write,
                               input logic [31:0] data);
    step_cycle();
    address_phase(addr, sram_bank_pkg::WORD, write, 1'b1);
    step_cycle();
    bus_idle();
    i_hwdata = data;
    for (int c = 0; c < 2; c++)
    begin
      @(negedge mem_hclk);
      assert (o_hready == (c == 1)) else value_error("o_hready", 32'(c == 1), 32'(o_hready));
      assert (o_hresp == sram_bank_pkg::ERROR)
        else value_error("o_hresp", 32'(sram_bank_pkg::ERROR), 32'(o_hresp));
    end
  endtask

  task automatic random_sub_write(input logic [15:0] base);
    logic [31:0] rnd;
    rnd = $random(seed);
    single_write({base[15:2], rnd[1], rnd[0] & !rnd[4]},
                 rnd[4] ? sram_bank_pkg::HALFWORD : sram_bank_pkg::BYTE, $random(seed));
  endtask

  initial
  begin
    logic [31:0] rnd;
    logic [15:0] addr;
    logic [31:0] data;
    mem_hrst_b     = 1'b0;
    i_haddr        = '0;
    i_hsize        = sram_bank_pkg::WORD;
    i_hwdata       = '0;
    i_big_endian_b = 1'b1;
    bus_idle();
    repeat (4) @(posedge mem_hclk);
    #1;
    mem_hrst_b = 1'b1;
    @(negedge mem_hclk);
    assert (o_hready) else value_error("o_hready", 32'd1, 32'(o_hready));
    assert (o_hresp == sram_bank_pkg::OKAY)
      else value_error("o_hresp", 32'(sram_bank_pkg::OKAY), 32'(o_hresp));
    assert (o_idle) else value_error("o_idle", 32'd1, 32'(o_idle));

    for (int t = 0; t < 8; t++)   // word writes, then byte and halfword merges
    begin
      rnd  = $random(seed);
      addr = {rnd[15:2], 2'b00};
      single_write(addr, sram_bank_pkg::WORD, $random(seed));
      if (t >= 4)
        repeat (3) random_sub_write(addr);
      single_read(addr, sram_bank_pkg::WORD);
    end

    for (int t = 0; t < 4; t++)
    begin
      rnd  = $random(seed);
      addr = {rnd[15:2], 2'b00};
      step_cycle();
      i_big_endian_b = 1'b0;
      single_write(addr, sram_bank_pkg::WORD, $random(seed));
      repeat (2) random_sub_write(addr);
      single_read({addr[15:2], rnd[17:16]}, sram_bank_pkg::BYTE);
      single_read({addr[15:2], rnd[18], 1'b0}, sram_bank_pkg::HALFWORD);
      single_read(addr, sram_bank_pkg::WORD);
      step_cycle();
      i_big_endian_b = 1'b1;   // ram contents seen little-endian
      single_read(addr, sram_bank_pkg::WORD);
    end

    repeat (3)
    begin
      rnd = $random(seed);
      write_then_read({rnd[15:2], 2'b00}, $random(seed));
    end

    rnd  = $random(seed);
    addr = {rnd[15:2], 2'b00};
    data = $random(seed);
    single_write(addr, sram_bank_pkg::WORD, data);
    denied_access(addr, 1'b1, ~data);
    denied_access(addr, 1'b0, '0);
    single_read(addr, sram_bank_pkg::WORD);

    step_cycle();
    @(negedge mem_hclk);
    assert (o_idle) else value_error("o_idle", 32'd1, 32'(o_idle));
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- design/sram_bank_top.sv
/*
  AHB SRAM bank top level.
  Access control, lane steering and the byte array.
*/
`timescale 1ns/1ns
`default_nettype none
`include "sram_bank_settings.svh"

module sram_bank_top (
  input  logic                              mem_hclk,
  input  logic                              mem_hrst_b,
  input  logic                              i_hsel,
  input  logic [`SRAM_BANK_ADDR_WIDTH-1:0]  i_haddr,
  input  sram_bank_pkg::htrans_e            i_htrans,
  input  sram_bank_pkg::hsize_e             i_hsize,
  input  logic                              i_hwrite,
  input  logic [`SRAM_BANK_DATA_WIDTH-1:0]  i_hwdata,
  input  logic                              i_big_endian_b,  // 1 = little-endian
  input  logic                              i_rd_deny,
  input  logic                              i_wr_deny,
  output logic [`SRAM_BANK_DATA_WIDTH-1:0]  o_hrdata,
  output logic                              o_hready,
  output sram_bank_pkg::hresp_e             o_hresp,
  output logic                              o_idle
);

  logic                             ram_sel;
  logic                             ram_write;
  logic [`SRAM_BANK_ADDR_WIDTH-1:0] ram_addr;
  sram_bank_pkg::hsize_e            ram_size;
  logic [`SRAM_BANK_DATA_WIDTH-1:0] ram_wdata;
  logic [`SRAM_BANK_DATA_WIDTH-1:0] ram_rdata;
  sram_bank_pkg::hsize_e            dp_size;
  logic [1:0]                       dp_lane;

  ahb_access_ctrl u_ctrl (
    .mem_hclk    (mem_hclk),
    .mem_hrst_b  (mem_hrst_b),
    .i_hsel      (i_hsel),
    .i_haddr     (i_haddr),
    .i_htrans    (i_htrans),
    .i_hsize     (i_hsize),
    .i_hwrite    (i_hwrite),
    .i_rd_deny   (i_rd_deny),
    .i_wr_deny   (i_wr_deny),
    .o_hready    (o_hready),
    .o_hresp     (o_hresp),
    .o_idle      (o_idle),
    .o_ram_sel   (ram_sel),
    .o_ram_write (ram_write),
    .o_ram_addr  (ram_addr),
    .o_ram_size  (ram_size),
    .o_dp_size   (dp_size),
    .o_dp_lane   (dp_lane)
  );

  byte_lane_steer u_steer (
    .i_big_endian_b (i_big_endian_b),
    .i_dp_size      (dp_size),
    .i_dp_lane      (dp_lane),
    .i_hwdata       (i_hwdata),
    .i_ram_rdata    (ram_rdata),
    .o_ram_wdata    (ram_wdata),
    .o_hrdata       (o_hrdata)
  );

  sram_byte_array u_array (
    .mem_hclk    (mem_hclk),
    .mem_hrst_b  (mem_hrst_b),
    .i_ram_sel   (ram_sel),
    .i_ram_write (ram_write),
    .i_ram_addr  (ram_addr),
    .i_ram_size  (ram_size),
    .i_ram_wdata (ram_wdata),
    .o_ram_rdata (ram_rdata)
  );

endmodule

`default_nettype wire

//--- design/sram_byte_array.sv
/*
  Byte-strobed single-port SRAM array.
  Registered read, output forced to zero after cycles without a read.
*/
`timescale 1ns/1ns
`default_nettype none
`include "sram_bank_settings.svh"

module sram_byte_array (
  input  logic                              mem_hclk,
  input  logic                              mem_hrst_b,
  input  logic                              i_ram_sel,
  input  logic                              i_ram_write,
  input  logic [`SRAM_BANK_ADDR_WIDTH-1:0]  i_ram_addr,
  input  sram_bank_pkg::hsize_e             i_ram_size,
  input  logic [`SRAM_BANK_DATA_WIDTH-1:0]  i_ram_wdata,
  output logic [`SRAM_BANK_DATA_WIDTH-1:0]  o_ram_rdata
);

  logic [`SRAM_BANK_DATA_WIDTH-1:0]      mem [0:`SRAM_BANK_DEPTH-1];
  logic [`SRAM_BANK_DATA_WIDTH-1:0]      rdata_q;
  logic [`SRAM_BANK_WORD_ADDR_WIDTH-1:0] word_idx;
  logic [`SRAM_BANK_BYTES-1:0]           byte_strb;
  logic                                  rd_sel_q;

  assign word_idx = i_ram_addr[`SRAM_BANK_ADDR_WIDTH-1:2];

  always_comb
  begin
    byte_strb = '0;
    case (i_ram_size)
      sram_bank_pkg::BYTE:     byte_strb[i_ram_addr[1:0]] = 1'b1;
      sram_bank_pkg::HALFWORD: byte_strb[{i_ram_addr[1], 1'b0} +: 2] = 2'b11;
      sram_bank_pkg::WORD:     byte_strb = '1;
      default:                 byte_strb = '0;   // no lanes
    endcase
  end

  always_ff @(posedge mem_hclk)
  begin
    if (i_ram_sel && i_ram_write)
    begin
      for (int b = 0; b < `SRAM_BANK_BYTES; b++)
      begin
        if (byte_strb[b])
          mem[word_idx][b*8 +: 8] <= i_ram_wdata[b*8 +: 8];
      end
    end
    if (i_ram_sel && !i_ram_write)
      rdata_q <= mem[word_idx];
  end

  always_ff @(posedge mem_hclk or negedge mem_hrst_b)
  begin
    if (!mem_hrst_b)
      rd_sel_q <= 1'b0;
    else
      rd_sel_q <= i_ram_sel && !i_ram_write;
  end

  assign o_ram_rdata = rd_sel_q ? rdata_q : '0;

endmodule

`default_nettype wire

//--- design/byte_lane_steer.sv
/*
  Byte lane steering for big-endian access.
  Mirrors the accessed byte or halfword between bus and RAM lanes,
  passes data through in little-endian mode.
*/
`timescale 1ns/1ns
`default_nettype none
`include "sram_bank_settings.svh"

module byte_lane_steer (
  input  logic                              i_big_endian_b,
  input  sram_bank_pkg::hsize_e             i_dp_size,
  input  logic [1:0]                        i_dp_lane,
  input  logic [`SRAM_BANK_DATA_WIDTH-1:0]  i_hwdata,
  input  logic [`SRAM_BANK_DATA_WIDTH-1:0]  i_ram_rdata,
  output logic [`SRAM_BANK_DATA_WIDTH-1:0]  o_ram_wdata,
  output logic [`SRAM_BANK_DATA_WIDTH-1:0]  o_hrdata
);

  logic [1:0] unit_pos;
  logic [1:0] mirror_pos;

  // copy one unit from byte position src to dst, rest zero
  function automatic logic [`SRAM_BANK_DATA_WIDTH-1:0] lane_move(
    input logic [`SRAM_BANK_DATA_WIDTH-1:0] data,
    input sram_bank_pkg::hsize_e            size,
    input logic [1:0]                       src,
    input logic [1:0]                       dst
  );
    logic [`SRAM_BANK_DATA_WIDTH-1:0] res;
    res = '0;
    case (size)
      sram_bank_pkg::BYTE:
        res[dst*8 +: 8] = data[src*8 +: 8];
      sram_bank_pkg::HALFWORD:
        res[dst*8 +: 16] = data[src*8 +: 16];
      sram_bank_pkg::WORD:
        res = data;
      default:
        res = '0;
    endcase
    return res;
  endfunction

  // halfwords sit on byte 0 or 2
  assign unit_pos   = (i_dp_size == sram_bank_pkg::HALFWORD) ? {i_dp_lane[1], 1'b0}
                                                             : i_dp_lane;
  assign mirror_pos = (i_dp_size == sram_bank_pkg::HALFWORD) ? {~i_dp_lane[1], 1'b0}
                                                             : ~i_dp_lane;

  assign o_hrdata    = i_big_endian_b ? i_ram_rdata
                       : lane_move(i_ram_rdata, i_dp_size, unit_pos, mirror_pos);
  assign o_ram_wdata = i_big_endian_b ? i_hwdata
                       : lane_move(i_hwdata, i_dp_size, mirror_pos, unit_pos);

endmodule

`default_nettype wire

//--- design/ahb_access_ctrl.sv
/*
  AHB access control for the SRAM bank.
  Qualifies address phases, sequences the two-cycle ERROR response for denied
  accesses, buffers writes into their data phase and arbitrates the RAM port.
*/
`timescale 1ns/1ns
`default_nettype none
`include "sram_bank_settings.svh"

module ahb_access_ctrl (
  input  logic                              mem_hclk,
  input  logic                              mem_hrst_b,
  input  logic                              i_hsel,
  input  logic [`SRAM_BANK_ADDR_WIDTH-1:0]  i_haddr,
  input  sram_bank_pkg::htrans_e            i_htrans,
  input  sram_bank_pkg::hsize_e             i_hsize,
  input  logic                              i_hwrite,
  input  logic                              i_rd_deny,
  input  logic                              i_wr_deny,
  output logic                              o_hready,
  output sram_bank_pkg::hresp_e             o_hresp,
  output logic                              o_idle,
  output logic                              o_ram_sel,
  output logic                              o_ram_write,
  output logic [`SRAM_BANK_ADDR_WIDTH-1:0]  o_ram_addr,
  output sram_bank_pkg::hsize_e             o_ram_size,
  output sram_bank_pkg::hsize_e             o_dp_size,
  output logic [1:0]                        o_dp_lane
);

  logic                             addr_act;
  logic                             addr_deny;
  logic                             rd_req;
  logic                             wb_valid;
  logic                             held_valid;
  logic [`SRAM_BANK_ADDR_WIDTH-1:0] ap_addr_q;
  sram_bank_pkg::hsize_e            ap_size_q;
  sram_bank_pkg::deny_state_e       deny_state;
  sram_bank_pkg::deny_state_e       deny_next;

  assign addr_act = i_hsel && o_hready &&
                    ((i_htrans == sram_bank_pkg::NONSEQ) ||
                     (i_htrans == sram_bank_pkg::SEQ));
  assign addr_deny = addr_act && (i_hwrite ? i_wr_deny : i_rd_deny);
  assign rd_req    = addr_act && !i_hwrite && !addr_deny;

  // last accepted address phase, shared by write buffer, held read and data phase
  always_ff @(posedge mem_hclk)
  begin
    if (o_hready)
    begin
      ap_addr_q <= i_haddr;
      ap_size_q <= i_hsize;
    end
  end

  always_ff @(posedge mem_hclk or negedge mem_hrst_b)
  begin
    if (!mem_hrst_b)
    begin
      wb_valid   <= 1'b0;
      held_valid <= 1'b0;
      deny_state <= sram_bank_pkg::DENY_IDLE;
    end
    else
    begin
      wb_valid   <= addr_act && i_hwrite && !addr_deny;
      held_valid <= rd_req && wb_valid;   // read loses the port to the buffer
      deny_state <= deny_next;
    end
  end

  always_comb
  begin
    deny_next = deny_state;
    case (deny_state)
      sram_bank_pkg::DENY_IDLE:
        if (addr_deny)
          deny_next = sram_bank_pkg::DENY_FIRST;
      sram_bank_pkg::DENY_FIRST:
        deny_next = sram_bank_pkg::DENY_LAST;
      sram_bank_pkg::DENY_LAST:
        deny_next = addr_deny ? sram_bank_pkg::DENY_FIRST : sram_bank_pkg::DENY_IDLE;
      default:
        deny_next = sram_bank_pkg::DENY_IDLE;
    endcase
  end

  // write buffer first, then a held read, then the live read
  always_comb
  begin
    if (wb_valid || held_valid)
    begin
      o_ram_sel   = 1'b1;
      o_ram_write = wb_valid;
      o_ram_addr  = ap_addr_q;
      o_ram_size  = ap_size_q;
    end
    else
    begin
      o_ram_sel   = rd_req;
      o_ram_write = 1'b0;
      o_ram_addr  = i_haddr;
      o_ram_size  = i_hsize;
    end
  end

  assign o_hready = !held_valid && (deny_state != sram_bank_pkg::DENY_FIRST);
  assign o_hresp  = (deny_state == sram_bank_pkg::DENY_IDLE) ? sram_bank_pkg::OKAY
                                                             : sram_bank_pkg::ERROR;
  assign o_idle   = !addr_act && !wb_valid && !held_valid;

  assign o_dp_size = ap_size_q;
  assign o_dp_lane = ap_addr_q[1:0];

endmodule

`default_nettype wire

//--- design/sram_bank_pkg.sv
/*
  SRAM bank types.
  AHB transfer, size and response encodings plus the deny response states.
*/
`default_nettype none

package sram_bank_pkg;

  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  // codes above WORD are not decoded
  typedef enum logic [2:0] {
    BYTE     = 3'b000,
    HALFWORD = 3'b001,
    WORD     = 3'b010
  } hsize_e;

  typedef enum logic [1:0] {
    OKAY  = 2'b00,
    ERROR = 2'b01
  } hresp_e;

  typedef enum logic [1:0] {
    DENY_IDLE,
    DENY_FIRST,   // error with hready low
    DENY_LAST     // error with hready high
  } deny_state_e;

endpackage

`default_nettype wire

//--- include/sram_bank_settings.svh
/*
  SRAM bank build settings.
  Fixed geometry of the AHB SRAM bank and its bus widths.
*/
`ifndef SRAM_BANK_SETTINGS_SVH
`define SRAM_BANK_SETTINGS_SVH

// byte address bits decoded by the bank
`define SRAM_BANK_ADDR_WIDTH 16

`define SRAM_BANK_DATA_WIDTH 32   // bus and ram word
`define SRAM_BANK_BYTES 4         // byte lanes per word

// word index into the array
`define SRAM_BANK_WORD_ADDR_WIDTH 14
`define SRAM_BANK_DEPTH 16384

`endif
